// ==== common/alsaqr_settings.svh ====
/* Build-time sizes, region map and register indices of the configuration glue.
   Included by the package, the RTL blocks and the testbench. */

`ifndef ALSAQR_SETTINGS_SVH
`define ALSAQR_SETTINGS_SVH

// Configuration port
`define ALSAQR_DATA_W        32
`define ALSAQR_CFG_ADDR_W    8

// Cluster-to-host address space, 4 KiB pages
`define ALSAQR_ADDR_W        32
`define ALSAQR_PAGE_OFS_W    12

`define ALSAQR_NUM_PADS      14
// At most 4 entries fit in the 4-bit register index
`define ALSAQR_TLB_ENTRIES   4

// Values of cfg address bits 7:6, region 3 is left unmapped
`define ALSAQR_REGION_CTRL   0
`define ALSAQR_REGION_PAD    1
`define ALSAQR_REGION_TLB    2
`define ALSAQR_UNMAPPED_DATA 32'hBADCAB1E

// Word indices inside the control region
`define ALSAQR_REG_CTRL      0
`define ALSAQR_REG_MAILBOX   1
`define ALSAQR_REG_STATUS    2

`endif

// ==== common/alsaqr_pkg.sv ====
/* Shared types of the configuration glue: data widths, bus structs and pad functions.
   Referenced with scoped names by every RTL block and the testbench. */

`include "alsaqr_settings.svh"

package alsaqr_pkg;

  typedef logic [`ALSAQR_DATA_W-1:0]                     cfg_data_t;
  typedef logic [`ALSAQR_CFG_ADDR_W-1:0]                 cfg_addr_t;
  // Word index, taken from cfg address bits 5:2
  typedef logic [3:0]                                    reg_idx_t;
  typedef logic [`ALSAQR_ADDR_W-1:0]                     addr_t;
  typedef logic [`ALSAQR_ADDR_W-`ALSAQR_PAGE_OFS_W-1:0] page_t;
  typedef logic [`ALSAQR_NUM_PADS-1:0]                   pad_vec_t;

  typedef enum logic [1:0] {
    FUNC_GPIO    = 2'd0,
    FUNC_UART_TX = 2'd1,
    FUNC_UART_RX = 2'd2,
    FUNC_OFF     = 2'd3
  } pad_func_e;

  typedef struct packed {
    logic      valid;
    logic      write;
    cfg_addr_t addr;
    cfg_data_t wdata;
  } cfg_req_t;

  typedef struct packed {
    logic      valid;
    logic      error;
    cfg_data_t rdata;
  } cfg_rsp_t;

  // Write strobe towards a single block
  typedef struct packed {
    logic      valid;
    reg_idx_t  idx;
    cfg_data_t wdata;
  } blk_wr_t;

  typedef struct packed {
    pad_vec_t out;
    pad_vec_t oe;
  } pad_drive_t;

  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
  } xlat_req_t;

  typedef struct packed {
    logic  valid;
    logic  hit;
    logic  error;
    addr_t addr;
  } xlat_rsp_t;

endpackage

// ==== source/cfg_decoder.sv ====
/* Splits configuration requests into the control, padframe and TLB blocks.
   Each request gets one response a cycle later with the registered read data. */

`include "alsaqr_settings.svh"

module cfg_decoder (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  alsaqr_pkg::cfg_req_t cfg_req_i,
  output alsaqr_pkg::cfg_rsp_t cfg_rsp_o,
  output alsaqr_pkg::blk_wr_t  ctrl_wr_o,
  output alsaqr_pkg::blk_wr_t  pad_wr_o,
  output alsaqr_pkg::blk_wr_t  tlb_wr_o,
  output alsaqr_pkg::reg_idx_t rd_idx_o,
  input  alsaqr_pkg::cfg_data_t ctrl_rdata_i,
  input  alsaqr_pkg::cfg_data_t pad_rdata_i,
  input  alsaqr_pkg::cfg_data_t tlb_rdata_i
);

  logic [1:0]            region;
  logic                  wr_en;
  logic                  unmapped;
  alsaqr_pkg::cfg_data_t rdata_d;
  alsaqr_pkg::cfg_rsp_t  rsp_q;

  assign region   = cfg_req_i.addr[7:6];
  assign rd_idx_o = cfg_req_i.addr[5:2];
  assign wr_en    = cfg_req_i.valid & cfg_req_i.write;
  assign unmapped = (region != 2'(`ALSAQR_REGION_CTRL)) &&
                    (region != 2'(`ALSAQR_REGION_PAD))  &&
                    (region != 2'(`ALSAQR_REGION_TLB));

  // Same index and data to all blocks, only the strobe is decoded
  assign ctrl_wr_o = '{valid: wr_en && (region == 2'(`ALSAQR_REGION_CTRL)),
                       idx: cfg_req_i.addr[5:2], wdata: cfg_req_i.wdata};
  assign pad_wr_o  = '{valid: wr_en && (region == 2'(`ALSAQR_REGION_PAD)),
                       idx: cfg_req_i.addr[5:2], wdata: cfg_req_i.wdata};
  assign tlb_wr_o  = '{valid: wr_en && (region == 2'(`ALSAQR_REGION_TLB)),
                       idx: cfg_req_i.addr[5:2], wdata: cfg_req_i.wdata};

  // Writes answer with zero data
  always_comb begin
    rdata_d = '0;
    if (cfg_req_i.valid && !cfg_req_i.write) begin
      case (region)
        2'(`ALSAQR_REGION_CTRL): rdata_d = ctrl_rdata_i;
        2'(`ALSAQR_REGION_PAD):  rdata_d = pad_rdata_i;
        2'(`ALSAQR_REGION_TLB):  rdata_d = tlb_rdata_i;
        default:                 rdata_d = `ALSAQR_UNMAPPED_DATA;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_q <= '0;
    end else begin
      rsp_q.valid <= cfg_req_i.valid;
      rsp_q.error <= cfg_req_i.valid & unmapped;
      rsp_q.rdata <= rdata_d;
    end
  end

  assign cfg_rsp_o = rsp_q;

endmodule

// ==== source/cluster_ctrl.sv ====
/* Cluster control registers: fetch enable, standalone boot and the host mailbox IRQ.
   Also brings the cluster end-of-computation level into clk_i for the status word. */

`include "alsaqr_settings.svh"

module cluster_ctrl (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  alsaqr_pkg::blk_wr_t   wr_i,
  input  alsaqr_pkg::reg_idx_t  rd_idx_i,
  output alsaqr_pkg::cfg_data_t rdata_o,
  input  logic                  cluster_eoc_i,
  output logic                  fetch_en_o,
  output logic                  en_sa_boot_o,
  output logic                  h2c_irq_o
);

  logic fetch_en_q;
  logic en_sa_boot_q;
  logic h2c_irq_q;
  logic eoc_meta_q;
  logic eoc_sync_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fetch_en_q   <= 1'b0;
      en_sa_boot_q <= 1'b0;
      h2c_irq_q    <= 1'b0;
    end else if (wr_i.valid) begin
      if (wr_i.idx == 4'(`ALSAQR_REG_CTRL)) begin
        fetch_en_q   <= wr_i.wdata[0];
        en_sa_boot_q <= wr_i.wdata[1];
      end
      if (wr_i.idx == 4'(`ALSAQR_REG_MAILBOX)) begin
        h2c_irq_q <= wr_i.wdata[0];
      end
    end
  end

  // eoc comes from the cluster clock domain
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      eoc_meta_q <= 1'b0;
      eoc_sync_q <= 1'b0;
    end else begin
      eoc_meta_q <= cluster_eoc_i;
      eoc_sync_q <= eoc_meta_q;
    end
  end

  always_comb begin
    rdata_o = '0;
    case (rd_idx_i)
      4'(`ALSAQR_REG_CTRL):    rdata_o[1:0] = {en_sa_boot_q, fetch_en_q};
      4'(`ALSAQR_REG_MAILBOX): rdata_o[0]   = h2c_irq_q;
      4'(`ALSAQR_REG_STATUS):  rdata_o[0]   = eoc_sync_q;
      default:                 rdata_o      = '0;
    endcase
  end

  assign fetch_en_o   = fetch_en_q;
  assign en_sa_boot_o = en_sa_boot_q;
  assign h2c_irq_o    = h2c_irq_q;

endmodule

// ==== padframe/periph_padframe.sv ====
/* Peripheral padframe with one function select per pad.
   Routes every pad to GPIO or the UART, or parks it; selects are set over the config port. */

`include "alsaqr_settings.svh"

module periph_padframe (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  alsaqr_pkg::blk_wr_t    wr_i,
  input  alsaqr_pkg::reg_idx_t   rd_idx_i,
  output alsaqr_pkg::cfg_data_t  rdata_o,
  input  alsaqr_pkg::pad_drive_t gpio_i,
  output alsaqr_pkg::pad_vec_t   gpio_in_o,
  input  logic                   uart_tx_i,
  output logic                   uart_rx_o,
  output alsaqr_pkg::pad_drive_t pad_o,
  input  alsaqr_pkg::pad_vec_t   pad_in_i
);

  alsaqr_pkg::pad_func_e sel_q [`ALSAQR_NUM_PADS];

  // Select registers, one per pad, at index k
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int k = 0; k < `ALSAQR_NUM_PADS; k++) begin
        sel_q[k] <= alsaqr_pkg::FUNC_GPIO;
      end
    end else if (wr_i.valid) begin
      for (int k = 0; k < `ALSAQR_NUM_PADS; k++) begin
        if (wr_i.idx == k) begin
          sel_q[k] <= alsaqr_pkg::pad_func_e'(wr_i.wdata[1:0]);
        end
      end
    end
  end

  // Indices past the last pad read as zero
  always_comb begin
    rdata_o = '0;
    for (int k = 0; k < `ALSAQR_NUM_PADS; k++) begin
      if (rd_idx_i == k) begin
        rdata_o[1:0] = sel_q[k];
      end
    end
  end

  // Pad outputs and the GPIO input path
  always_comb begin
    pad_o     = '0;
    gpio_in_o = '0;
    for (int k = 0; k < `ALSAQR_NUM_PADS; k++) begin
      case (sel_q[k])
        alsaqr_pkg::FUNC_GPIO: begin
          pad_o.out[k] = gpio_i.out[k];
          pad_o.oe[k]  = gpio_i.oe[k];
          gpio_in_o[k] = pad_in_i[k];
        end
        alsaqr_pkg::FUNC_UART_TX: begin
          pad_o.out[k] = uart_tx_i;
          pad_o.oe[k]  = 1'b1;
        end
        // RX and OFF leave the pad undriven
        default: begin
          pad_o.out[k] = 1'b0;
          pad_o.oe[k]  = 1'b0;
        end
      endcase
    end
  end

  // Lowest RX pad wins, so scan from the top down
  always_comb begin
    uart_rx_o = 1'b1;
    for (int k = `ALSAQR_NUM_PADS - 1; k >= 0; k--) begin
      if (sel_q[k] == alsaqr_pkg::FUNC_UART_RX) begin
        uart_rx_o = pad_in_i[k];
      end
    end
  end

endmodule

// ==== c2h_tlb/c2h_tlb.sv ====
/* Cluster-to-host translation table with a priority page-range match.
   Entries are written over the config port; each lookup answers one cycle later. */

`include "alsaqr_settings.svh"

module c2h_tlb (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  alsaqr_pkg::blk_wr_t   wr_i,
  input  alsaqr_pkg::reg_idx_t  rd_idx_i,
  output alsaqr_pkg::cfg_data_t rdata_o,
  input  alsaqr_pkg::xlat_req_t xlat_req_i,
  output alsaqr_pkg::xlat_rsp_t xlat_rsp_o
);

  alsaqr_pkg::page_t first_q [`ALSAQR_TLB_ENTRIES];
  alsaqr_pkg::page_t last_q  [`ALSAQR_TLB_ENTRIES];
  alsaqr_pkg::page_t base_q  [`ALSAQR_TLB_ENTRIES];
  logic [`ALSAQR_TLB_ENTRIES-1:0] valid_q;
  logic [`ALSAQR_TLB_ENTRIES-1:0] ro_q;

  alsaqr_pkg::page_t     req_page;
  alsaqr_pkg::xlat_rsp_t rsp_d;
  alsaqr_pkg::xlat_rsp_t rsp_q;

  // Index bits 3:2 pick the entry, bits 1:0 the field
  always_ff @(posedge clk_i) begin
    for (int e = 0; e < `ALSAQR_TLB_ENTRIES; e++) begin
      if (wr_i.valid && (wr_i.idx[3:2] == e)) begin
        case (wr_i.idx[1:0])
          2'd0:    first_q[e] <= wr_i.wdata[$bits(alsaqr_pkg::page_t)-1:0];
          2'd1:    last_q[e]  <= wr_i.wdata[$bits(alsaqr_pkg::page_t)-1:0];
          2'd2:    base_q[e]  <= wr_i.wdata[$bits(alsaqr_pkg::page_t)-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
      ro_q    <= '0;
    end else begin
      for (int e = 0; e < `ALSAQR_TLB_ENTRIES; e++) begin
        if (wr_i.valid && (wr_i.idx[3:2] == e) && (wr_i.idx[1:0] == 2'd3)) begin
          valid_q[e] <= wr_i.wdata[0];
          ro_q[e]    <= wr_i.wdata[1];
        end
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    for (int e = 0; e < `ALSAQR_TLB_ENTRIES; e++) begin
      if (rd_idx_i[3:2] == e) begin
        case (rd_idx_i[1:0])
          2'd0:    rdata_o = alsaqr_pkg::cfg_data_t'(first_q[e]);
          2'd1:    rdata_o = alsaqr_pkg::cfg_data_t'(last_q[e]);
          2'd2:    rdata_o = alsaqr_pkg::cfg_data_t'(base_q[e]);
          default: rdata_o = alsaqr_pkg::cfg_data_t'({ro_q[e], valid_q[e]});
        endcase
      end
    end
  end

  assign req_page = xlat_req_i.addr[`ALSAQR_ADDR_W-1:`ALSAQR_PAGE_OFS_W];

  // Priority match; scanning downwards leaves the lowest hit in place
  always_comb begin
    alsaqr_pkg::page_t xlat_page;
    logic              ro_hit;
    xlat_page = '0;
    ro_hit    = 1'b0;
    rsp_d     = '0;
    for (int e = `ALSAQR_TLB_ENTRIES - 1; e >= 0; e--) begin
      if (valid_q[e] && (req_page >= first_q[e]) && (req_page <= last_q[e])) begin
        rsp_d.hit = 1'b1;
        xlat_page = base_q[e] + (req_page - first_q[e]);
        ro_hit    = ro_q[e];
      end
    end
    rsp_d.valid = xlat_req_i.valid;
    rsp_d.error = !rsp_d.hit || (xlat_req_i.write && ro_hit);
    if (!rsp_d.error) begin
      rsp_d.addr = {xlat_page, xlat_req_i.addr[`ALSAQR_PAGE_OFS_W-1:0]};
    end
  end

  // Single lookup stage
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_q.valid <= 1'b0;
    end else begin
      rsp_q.valid <= rsp_d.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    rsp_q.hit   <= rsp_d.hit;
    rsp_q.error <= rsp_d.error;
    rsp_q.addr  <= rsp_d.addr;
  end

  assign xlat_rsp_o = rsp_q;

endmodule

// ==== source/alsaqr_lite.sv ====
/* Top level of the host-side configuration glue.
   Connects the config decoder to the cluster control, padframe and translation table. */

module alsaqr_lite (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  alsaqr_pkg::cfg_req_t   cfg_req_i,
  output alsaqr_pkg::cfg_rsp_t   cfg_rsp_o,
  input  logic                   cluster_eoc_i,
  output logic                   fetch_en_o,
  output logic                   en_sa_boot_o,
  output logic                   h2c_irq_o,
  input  alsaqr_pkg::pad_drive_t gpio_i,
  output alsaqr_pkg::pad_vec_t   gpio_in_o,
  input  logic                   uart_tx_i,
  output logic                   uart_rx_o,
  output alsaqr_pkg::pad_drive_t pad_o,
  input  alsaqr_pkg::pad_vec_t   pad_in_i,
  input  alsaqr_pkg::xlat_req_t  xlat_req_i,
  output alsaqr_pkg::xlat_rsp_t  xlat_rsp_o
);

  alsaqr_pkg::blk_wr_t   ctrl_wr;
  alsaqr_pkg::blk_wr_t   pad_wr;
  alsaqr_pkg::blk_wr_t   tlb_wr;
  alsaqr_pkg::reg_idx_t  rd_idx;
  alsaqr_pkg::cfg_data_t ctrl_rdata;
  alsaqr_pkg::cfg_data_t pad_rdata;
  alsaqr_pkg::cfg_data_t tlb_rdata;

  cfg_decoder i_cfg_decoder (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .cfg_req_i    ( cfg_req_i  ),
    .cfg_rsp_o    ( cfg_rsp_o  ),
    .ctrl_wr_o    ( ctrl_wr    ),
    .pad_wr_o     ( pad_wr     ),
    .tlb_wr_o     ( tlb_wr     ),
    .rd_idx_o     ( rd_idx     ),
    .ctrl_rdata_i ( ctrl_rdata ),
    .pad_rdata_i  ( pad_rdata  ),
    .tlb_rdata_i  ( tlb_rdata  )
  );

  cluster_ctrl i_cluster_ctrl (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .wr_i          ( ctrl_wr       ),
    .rd_idx_i      ( rd_idx        ),
    .rdata_o       ( ctrl_rdata    ),
    .cluster_eoc_i ( cluster_eoc_i ),
    .fetch_en_o    ( fetch_en_o    ),
    .en_sa_boot_o  ( en_sa_boot_o  ),
    .h2c_irq_o     ( h2c_irq_o     )
  );

  periph_padframe i_periph_padframe (
    .clk_i     ( clk_i     ),
    .reset_i   ( reset_i   ),
    .wr_i      ( pad_wr    ),
    .rd_idx_i  ( rd_idx    ),
    .rdata_o   ( pad_rdata ),
    .gpio_i    ( gpio_i    ),
    .gpio_in_o ( gpio_in_o ),
    .uart_tx_i ( uart_tx_i ),
    .uart_rx_o ( uart_rx_o ),
    .pad_o     ( pad_o     ),
    .pad_in_i  ( pad_in_i  )
  );

  c2h_tlb i_c2h_tlb (
    .clk_i      ( clk_i      ),
    .reset_i    ( reset_i    ),
    .wr_i       ( tlb_wr     ),
    .rd_idx_i   ( rd_idx     ),
    .rdata_o    ( tlb_rdata  ),
    .xlat_req_i ( xlat_req_i ),
    .xlat_rsp_o ( xlat_rsp_o )
  );

endmodule

// ==== tests/tb_alsaqr_lite.sv ====
/* Testbench of the configuration glue driving the config port, pads and lookups.
   Assertions compare the DUT against reference values kept in the testbench. */

`include "alsaqr_settings.svh"

module tb_alsaqr_lite;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 20;
  localparam int EOC_POLLS      = 4;
  localparam int N_PADS         = `ALSAQR_NUM_PADS;
  localparam int N_TLB          = `ALSAQR_TLB_ENTRIES;
  localparam alsaqr_pkg::page_t PROBE_PAGES [10] = '{
    20'h00010, 20'h00015, 20'h0001C, 20'h0001F, 20'h00020,
    20'h00027, 20'h00028, 20'h00040, 20'h0004F, 20'h00150
  };

  logic                   clk_i;
  logic                   reset_i;
  alsaqr_pkg::cfg_req_t   cfg_req_i;
  alsaqr_pkg::cfg_rsp_t   cfg_rsp_o;
  logic                   cluster_eoc_i;
  logic                   fetch_en_o;
  logic                   en_sa_boot_o;
  logic                   h2c_irq_o;
  alsaqr_pkg::pad_drive_t gpio_i;
  alsaqr_pkg::pad_vec_t   gpio_in_o;
  logic                   uart_tx_i;
  logic                   uart_rx_o;
  alsaqr_pkg::pad_drive_t pad_o;
  alsaqr_pkg::pad_vec_t   pad_in_i;
  alsaqr_pkg::xlat_req_t  xlat_req_i;
  alsaqr_pkg::xlat_rsp_t  xlat_rsp_o;

  // Reference state, updated once the DUT has taken a write
  logic                   exp_fetch;
  logic                   exp_boot;
  logic                   exp_irq;
  alsaqr_pkg::pad_func_e  exp_sel [N_PADS];
  alsaqr_pkg::page_t      tlb_first [N_TLB];
  alsaqr_pkg::page_t      tlb_last [N_TLB];
  alsaqr_pkg::page_t      tlb_base [N_TLB];
  logic [1:0]             tlb_flags [N_TLB];
  alsaqr_pkg::pad_drive_t exp_pad;
  alsaqr_pkg::pad_vec_t   exp_gpio_in;
  logic                   exp_rx;
  alsaqr_pkg::cfg_rsp_t   exp_rsp_q;
  logic                   rsp_data_known_q;
  alsaqr_pkg::xlat_rsp_t  exp_xlat_q;

  int                     errors;
  int                     reads;
  int                     lookups;
  integer                 seed = 49049;
  logic [31:0]            rnd;

  alsaqr_lite DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic alsaqr_pkg::xlat_rsp_t ref_xlat(input alsaqr_pkg::xlat_req_t req);
    alsaqr_pkg::xlat_rsp_t r;
    alsaqr_pkg::page_t     pg;
    int                    hit_e;
    r     = '0;
    pg    = req.addr[`ALSAQR_ADDR_W-1:`ALSAQR_PAGE_OFS_W];
    hit_e = -1;
    for (int e = 0; e < N_TLB; e++) begin
      if (hit_e < 0 && tlb_flags[e][0] && pg >= tlb_first[e] && pg <= tlb_last[e]) begin
        hit_e = e;
      end
    end
    r.valid = req.valid;
    r.hit   = (hit_e >= 0);
    if (!r.hit || (req.write && tlb_flags[hit_e][1])) begin
      r.error = 1'b1;
    end else begin
      r.addr = {tlb_base[hit_e] + (pg - tlb_first[hit_e]), req.addr[`ALSAQR_PAGE_OFS_W-1:0]};
    end
    return r;
  endfunction

  // Pad routing table with the lowest RX pad feeding the UART
  always_comb begin
    logic rx_found;
    rx_found    = 1'b0;
    exp_pad     = '0;
    exp_gpio_in = '0;
    exp_rx      = 1'b1;
    for (int k = 0; k < N_PADS; k++) begin
      if (exp_sel[k] == alsaqr_pkg::FUNC_GPIO) begin
        exp_pad.out[k] = gpio_i.out[k];
        exp_pad.oe[k]  = gpio_i.oe[k];
        exp_gpio_in[k] = pad_in_i[k];
      end else if (exp_sel[k] == alsaqr_pkg::FUNC_UART_TX) begin
        exp_pad.out[k] = uart_tx_i;
        exp_pad.oe[k]  = 1'b1;
      end else if (exp_sel[k] == alsaqr_pkg::FUNC_UART_RX && !rx_found) begin
        exp_rx   = pad_in_i[k];
        rx_found = 1'b1;
      end
    end
  end

  // Expected responses one cycle behind the requests
  always @(posedge clk_i) begin
    if (reset_i) begin
      exp_rsp_q        <= '0;
      rsp_data_known_q <= 1'b0;
      exp_xlat_q       <= '0;
    end else begin
      exp_rsp_q.valid  <= cfg_req_i.valid;
      exp_rsp_q.error  <= cfg_req_i.valid && (cfg_req_i.addr[7:6] == 2'd3);
      exp_rsp_q.rdata  <= cfg_req_i.write ? '0 : `ALSAQR_UNMAPPED_DATA;
      rsp_data_known_q <= cfg_req_i.valid && (cfg_req_i.write || cfg_req_i.addr[7:6] == 2'd3);
      exp_xlat_q       <= ref_xlat(xlat_req_i);
    end
  end

  task automatic report_mismatch(input string name, input logic [63:0] exp, logic [63:0] act);
    errors++;
    $display("ERROR %s expected %h actual %h", name, exp, act);
  endtask

  assert property (@(posedge clk_i) disable iff (reset_i) cfg_rsp_o.valid == exp_rsp_q.valid)
    else report_mismatch("cfg_rsp_o.valid", $sampled(exp_rsp_q.valid), $sampled(cfg_rsp_o.valid));
  assert property (@(posedge clk_i) disable iff (reset_i)
                   exp_rsp_q.valid |-> cfg_rsp_o.error == exp_rsp_q.error)
    else report_mismatch("cfg_rsp_o.error", $sampled(exp_rsp_q.error), $sampled(cfg_rsp_o.error));
  assert property (@(posedge clk_i) disable iff (reset_i)
                   rsp_data_known_q |-> cfg_rsp_o.rdata == exp_rsp_q.rdata)
    else report_mismatch("cfg_rsp_o.rdata", $sampled(exp_rsp_q.rdata), $sampled(cfg_rsp_o.rdata));
  assert property (@(posedge clk_i) disable iff (reset_i) fetch_en_o == exp_fetch)
    else report_mismatch("fetch_en_o", $sampled(exp_fetch), $sampled(fetch_en_o));
  assert property (@(posedge clk_i) disable iff (reset_i) en_sa_boot_o == exp_boot)
    else report_mismatch("en_sa_boot_o", $sampled(exp_boot), $sampled(en_sa_boot_o));
  assert property (@(posedge clk_i) disable iff (reset_i) h2c_irq_o == exp_irq)
    else report_mismatch("h2c_irq_o", $sampled(exp_irq), $sampled(h2c_irq_o));
  assert property (@(posedge clk_i) disable iff (reset_i) pad_o == exp_pad)
    else report_mismatch("pad_o", $sampled(exp_pad), $sampled(pad_o));
  assert property (@(posedge clk_i) disable iff (reset_i) gpio_in_o == exp_gpio_in)
    else report_mismatch("gpio_in_o", $sampled(exp_gpio_in), $sampled(gpio_in_o));
  assert property (@(posedge clk_i) disable iff (reset_i) uart_rx_o == exp_rx)
    else report_mismatch("uart_rx_o", $sampled(exp_rx), $sampled(uart_rx_o));
  assert property (@(posedge clk_i) disable iff (reset_i) xlat_rsp_o.valid == exp_xlat_q.valid)
    else report_mismatch("xlat_rsp_o.valid", $sampled(exp_xlat_q.valid),
                         $sampled(xlat_rsp_o.valid));
  assert property (@(posedge clk_i) disable iff (reset_i)
                   exp_xlat_q.valid |-> xlat_rsp_o == exp_xlat_q)
    else report_mismatch("xlat_rsp_o", $sampled(exp_xlat_q), $sampled(xlat_rsp_o));

  // One request, then wait at falling edges for its response
  task automatic cfg_access(input logic write, input logic [7:0] addr,
                            input alsaqr_pkg::cfg_data_t wdata,
                            output alsaqr_pkg::cfg_data_t rdata);
    bit got;
    got   = 1'b0;
    rdata = '0;
    @(posedge clk_i);
    cfg_req_i <= '{valid: 1'b1, write: write, addr: addr, wdata: wdata};
    @(posedge clk_i);
    cfg_req_i <= '0;
    for (int t = 0; t < TIMEOUT_CYCLES && !got; t++) begin
      @(negedge clk_i);
      if (cfg_rsp_o.valid) begin
        got   = 1'b1;
        rdata = cfg_rsp_o.rdata;
      end
    end
    if (!got) begin
      errors++;
      $display("No config response for address %h", addr);
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input alsaqr_pkg::cfg_data_t data);
    alsaqr_pkg::cfg_data_t unused;
    cfg_access(1'b1, addr, data, unused);
  endtask

  task automatic read_expect(input logic [7:0] addr, input alsaqr_pkg::cfg_data_t exp,
                             input string name);
    alsaqr_pkg::cfg_data_t got;
    cfg_access(1'b0, addr, '0, got);
    reads++;
    assert (got == exp)
      else report_mismatch($sformatf("cfg_rsp_o.rdata (%s)", name), exp, got);
  endtask

  task automatic poll_status(input logic level);
    alsaqr_pkg::cfg_data_t rdata;
    bit                    seen;
    seen = 1'b0;
    for (int p = 0; p < EOC_POLLS && !seen; p++) begin
      cfg_access(1'b0, 8'h08, '0, rdata);
      reads++;
      seen = (rdata[0] == level);
    end
    assert (seen) else begin
      errors++;
      $display("STATUS did not follow cluster_eoc_i to %0d", level);
    end
  endtask

  task automatic set_pad(input int k, input alsaqr_pkg::pad_func_e f);
    write_reg(8'(8'h40 + 4 * k), 32'(f));
    exp_sel[k] = f;
    read_expect(8'(8'h40 + 4 * k), 32'(f), "pad select rdata");
  endtask

  task automatic drive_pad_traffic(input int cycles);
    repeat (cycles) begin
      @(posedge clk_i);
      rnd = $random(seed);
      gpio_i    <= rnd[27:0];
      uart_tx_i <= rnd[31];
      rnd = $random(seed);
      pad_in_i  <= rnd[13:0];
    end
  endtask

  task automatic program_entry(input int e, input alsaqr_pkg::page_t first,
                               input alsaqr_pkg::page_t last, input alsaqr_pkg::page_t base,
                               input logic [1:0] flags);
    write_reg(8'(8'h80 + 16 * e), 32'(first));
    write_reg(8'(8'h84 + 16 * e), 32'(last));
    write_reg(8'(8'h88 + 16 * e), 32'(base));
    write_reg(8'(8'h8C + 16 * e), 32'(flags));
    tlb_first[e] = first;
    tlb_last[e]  = last;
    tlb_base[e]  = base;
    tlb_flags[e] = flags;
  endtask

  initial begin
    reset_i       = 1'b1;
    cfg_req_i     = '0;
    cluster_eoc_i = 1'b0;
    gpio_i        = '0;
    uart_tx_i     = 1'b0;
    pad_in_i      = '0;
    xlat_req_i    = '0;
    errors        = 0;
    reads         = 0;
    lookups       = 0;
    exp_fetch     = 1'b0;
    exp_boot      = 1'b0;
    exp_irq       = 1'b0;
    for (int k = 0; k < N_PADS; k++) begin
      exp_sel[k] = alsaqr_pkg::FUNC_GPIO;
    end
    for (int e = 0; e < N_TLB; e++) begin
      tlb_first[e] = '0;
      tlb_last[e]  = '0;
      tlb_base[e]  = '0;
      tlb_flags[e] = 2'b00;
    end
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    assert (!fetch_en_o && !en_sa_boot_o && !h2c_irq_o && !cfg_rsp_o.valid && !xlat_rsp_o.valid)
      else begin
        errors++;
        $display("Control outputs or response valids not cleared by reset");
      end
    drive_pad_traffic(8);

    // Back-to-back requests get one response per cycle
    @(posedge clk_i);
    for (int i = 0; i < 4; i++) begin
      cfg_req_i <= '{valid: 1'b1, write: 1'b0, addr: 8'(i) * 8'h44, wdata: '0};
      @(posedge clk_i);
    end
    cfg_req_i <= '0;

    write_reg(8'h00, 32'h1);
    exp_fetch = 1'b1;
    read_expect(8'h00, 32'h1, "ctrl rdata");
    write_reg(8'h00, 32'h2);
    exp_fetch = 1'b0;
    exp_boot  = 1'b1;
    read_expect(8'h00, 32'h2, "ctrl rdata");
    write_reg(8'h04, 32'h1);
    exp_irq = 1'b1;
    read_expect(8'h04, 32'h1, "mailbox rdata");
    write_reg(8'h04, 32'h0);
    exp_irq = 1'b0;
    // The mailbox is low here, so a stray unmapped write would raise the IRQ
    write_reg(8'hC4, 32'hFFFF_FFFF);
    read_expect(8'hC8, `ALSAQR_UNMAPPED_DATA, "unmapped rdata");

    @(posedge clk_i);
    cluster_eoc_i <= 1'b1;
    poll_status(1'b1);
    @(posedge clk_i);
    cluster_eoc_i <= 1'b0;
    poll_status(1'b0);

    // With two RX pads the lower one must win
    set_pad(3, alsaqr_pkg::FUNC_UART_RX);
    set_pad(9, alsaqr_pkg::FUNC_UART_RX);
    drive_pad_traffic(10);
    set_pad(3, alsaqr_pkg::FUNC_UART_TX);
    drive_pad_traffic(10);
    repeat (3) begin
      for (int k = 0; k < N_PADS; k++) begin
        rnd = $random(seed);
        set_pad(k, alsaqr_pkg::pad_func_e'(rnd[1:0]));
      end
      drive_pad_traffic(10);
    end
    read_expect(8'h78, 32'h0, "pad rdata past last pad");
    for (int k = 0; k < N_PADS; k++) begin
      set_pad(k, alsaqr_pkg::FUNC_GPIO);
    end
    drive_pad_traffic(10);

    // Entry 1 overlaps entry 0 and entry 3 stays invalid
    program_entry(0, 20'h00010, 20'h0001F, 20'h80000, 2'b01);
    program_entry(1, 20'h00018, 20'h00027, 20'h90000, 2'b11);
    program_entry(2, 20'h00040, 20'h0004F, 20'hA0000, 2'b11);
    program_entry(3, 20'h00100, 20'h001FF, 20'h00200, 2'b00);
    read_expect(8'h90, 32'h00018, "tlb first rdata");
    read_expect(8'hAC, 32'h3, "tlb flags rdata");

    @(posedge clk_i);
    for (int i = 0; i < 32; i++) begin
      rnd = $random(seed);
      xlat_req_i <= '{valid: rnd[30] | rnd[29], write: rnd[31],
                      addr: {PROBE_PAGES[rnd[15:12] % 10], rnd[11:0]}};
      lookups += int'(rnd[30] | rnd[29]);
      @(posedge clk_i);
    end
    xlat_req_i <= '0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);

    $display("Summary: %0d errors, %0d reads, %0d lookups", errors, reads, lookups);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== alsaqr_lite.f ====
+incdir+common
common/alsaqr_pkg.sv
source/cfg_decoder.sv
source/cluster_ctrl.sv
padframe/periph_padframe.sv
c2h_tlb/c2h_tlb.sv
source/alsaqr_lite.sv
tests/tb_alsaqr_lite.sv

// ==== Bender.yml ====
package:
  name: alsaqr_lite

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/alsaqr_pkg.sv
      - source/cfg_decoder.sv
      - source/cluster_ctrl.sv
      - padframe/periph_padframe.sv
      - c2h_tlb/c2h_tlb.sv
      - source/alsaqr_lite.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_alsaqr_lite.sv
